// ==== source/lcd_defines.svh ====
`ifndef LCD_DEFINES_SVH
`define LCD_DEFINES_SVH

// settle and pause times as clk_270k cycle counts
`define LCD_T_40MS 10800
// power-up wait before the first nibble

`define LCD_T_4_1MS 1107
// after the first 0x3 nibble

`define LCD_T_1_52MS 411
// clear display and return home

`define LCD_T_100US 27
// after the second 0x3 nibble

`define LCD_T_37US 10
// ordinary instruction or character write

`define LCD_T_500MS 135000
// refresh pause between frames

// wide enough for the longest count above
`define LCD_WAIT_W 18

// items held between text source and bus driver
`define LCD_FIFO_DEPTH 4

`endif

// ==== source/lcd_pkg.sv ====
package lcd_pkg;

	// value shown as eight hex digits on one line
	typedef logic [31:0] lcd_word_t;

	// what the bus driver does with an item
	typedef enum logic [1:0] {
		kind_pause, // no transfer, only the wait
		kind_upper, // command, upper nibble only
		kind_cmd,   // command, both nibbles, rs low
		kind_data   // character, both nibbles, rs high
	} lcd_kind_t;

	// settle time after an item
	typedef enum logic [2:0] {
		w_37us,
		w_100us,
		w_1_52ms,
		w_4_1ms,
		w_40ms,
		w_500ms
	} lcd_wait_t;

	// one entry of the item stream, 13 bits
	typedef struct packed {
		lcd_kind_t kind;
		lcd_wait_t wait_cls;
		logic [7:0] data;
	} lcd_item_t;

endpackage

// ==== source/lcd_text_source.sv ====
module lcd_text_source (
	input logic clk_270k,
	input logic rst,
	input lcd_pkg::lcd_word_t word_top,
	input lcd_pkg::lcd_word_t word_bottom,
	output logic wbw_cyc,
	output logic wbw_stb,
	output lcd_pkg::lcd_item_t wbw_dat,
	input logic wbw_ack
);
	import lcd_pkg::*;

	logic [4:0] step; // 0..8 init script, 9..31 frame
	logic req;
	lcd_word_t top_q; // shifted left once per digit sent
	lcd_word_t bottom_q;
	lcd_item_t item;

	function automatic lcd_item_t mk(lcd_kind_t kind, lcd_wait_t wait_cls, logic [7:0] data);
		lcd_item_t it;
		it.kind = kind;
		it.wait_cls = wait_cls;
		it.data = data;
		return it;
	endfunction

	// 0-9 -> '0'-'9', 10-15 -> 'A'-'F'
	function automatic logic [7:0] hex_char(logic [3:0] nib);
		if (nib < 4'd10)
			return {4'h3, nib};
		else
			return 8'h37 + {4'h0, nib};
	endfunction

	always_comb begin
		case (step) inside
			5'd0: item = mk(kind_pause, w_40ms, 8'h00);
			5'd1: item = mk(kind_upper, w_4_1ms, 8'h30);
			5'd2: item = mk(kind_upper, w_100us, 8'h30);
			5'd3: item = mk(kind_upper, w_37us, 8'h30);
			5'd4: item = mk(kind_upper, w_37us, 8'h20); // switch to 4-bit bus
			5'd5: item = mk(kind_cmd, w_37us, 8'h28); // two lines, 5x8
			5'd6: item = mk(kind_cmd, w_37us, 8'h0F);
			5'd7: item = mk(kind_cmd, w_1_52ms, 8'h01); // clear
			5'd8: item = mk(kind_cmd, w_37us, 8'h06);
			5'd9, 5'd20: item = mk(kind_data, w_37us, 8'h30); // '0'
			5'd10, 5'd21: item = mk(kind_data, w_37us, 8'h78); // 'x'
			[5'd11:5'd18]: item = mk(kind_data, w_37us, hex_char(top_q[31:28]));
			5'd19: item = mk(kind_cmd, w_37us, 8'hC0); // ddram 0x40, line 2
			[5'd22:5'd29]: item = mk(kind_data, w_37us, hex_char(bottom_q[31:28]));
			5'd30: item = mk(kind_cmd, w_1_52ms, 8'h02); // return home
			default: item = mk(kind_pause, w_500ms, 8'h00);
		endcase
	end

	assign wbw_dat = item;
	assign wbw_cyc = req;
	assign wbw_stb = req;

	always_ff @(posedge clk_270k) begin
		if (rst) begin
			step <= '0;
			req <= 1'b0;
		end else begin
			req <= 1'b1; // always something to send
			if (wbw_ack)
				step <= (step == 5'd31) ? 5'd9 : step + 5'd1;
		end
	end

	// word snapshot at frame start, then one nibble out per digit
	always_ff @(posedge clk_270k) begin
		if (wbw_ack) begin
			if (step == 5'd8 || step == 5'd31) begin
				top_q <= word_top;
				bottom_q <= word_bottom;
			end
			if (step inside {[5'd11:5'd18]})
				top_q <= top_q << 4;
			if (step inside {[5'd22:5'd29]})
				bottom_q <= bottom_q << 4;
		end
	end

endmodule

// ==== source/lcd_item_fifo.sv ====
`include "lcd_defines.svh"

module lcd_item_fifo #(
	parameter type item_t = lcd_pkg::lcd_item_t,
	parameter int depth = `LCD_FIFO_DEPTH
) (
	input logic clk_270k,
	input logic rst,
	input logic wbw_cyc,
	input logic wbw_stb,
	input item_t wbw_dat,
	output logic wbw_ack,
	input logic wbr_cyc,
	input logic wbr_stb,
	output logic wbr_ack,
	output item_t wbr_dat
);
	localparam int aw = (depth > 1) ? $clog2(depth) : 1;
	localparam int cw = $clog2(depth + 1);
	localparam logic [aw-1:0] last_ptr = aw'(depth - 1);
	localparam logic [cw-1:0] full_cnt = cw'(depth);

	item_t mem [depth];
	logic [aw-1:0] wptr;
	logic [aw-1:0] rptr;
	logic [cw-1:0] count;
	logic full;
	logic empty;
	logic wr_go;
	logic rd_go;

	assign full = (count == full_cnt);
	assign empty = (count == '0);

	// one ack per strobe, the ~ack term stops a double accept
	assign wr_go = wbw_cyc && wbw_stb && !wbw_ack && !full;
	assign rd_go = wbr_cyc && wbr_stb && !wbr_ack && !empty;

	always_ff @(posedge clk_270k) begin
		if (rst) begin
			wptr <= '0;
			rptr <= '0;
			count <= '0;
			wbw_ack <= 1'b0;
			wbr_ack <= 1'b0;
		end else begin
			wbw_ack <= wr_go;
			wbr_ack <= rd_go;
			if (wr_go)
				wptr <= (wptr == last_ptr) ? '0 : wptr + 1'b1;
			if (rd_go)
				rptr <= (rptr == last_ptr) ? '0 : rptr + 1'b1;
			if (wr_go && !rd_go)
				count <= count + 1'b1;
			else if (rd_go && !wr_go)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk_270k) begin
		if (wr_go)
			mem[wptr] <= wbw_dat;
		if (rd_go)
			wbr_dat <= mem[rptr]; // valid alongside wbr_ack
	end

endmodule

// ==== source/lcd_bus_driver.sv ====
`include "lcd_defines.svh"

module lcd_bus_driver (
	input logic clk_270k,
	input logic rst,
	output logic wbr_cyc,
	output logic wbr_stb,
	input logic wbr_ack,
	input lcd_pkg::lcd_item_t wbr_dat,
	output logic lcd_e,
	output logic lcd_rs,
	output logic [3:0] lcd_data
);
	import lcd_pkg::*;

	typedef enum logic [2:0] {
		st_req,    // waiting on the FIFO
		st_up_set, // upper nibble setup
		st_up_hi,  // e high
		st_up_lo,  // e low, nibble held
		st_lo_set,
		st_lo_hi,
		st_lo_lo,
		st_wait    // settle count
	} phase_t;

	phase_t state;
	logic req;
	lcd_item_t item_q;
	logic [`LCD_WAIT_W-1:0] cnt;

	function automatic logic [`LCD_WAIT_W-1:0] wait_count(lcd_wait_t w);
		case (w)
			w_100us: return `LCD_WAIT_W'(`LCD_T_100US);
			w_1_52ms: return `LCD_WAIT_W'(`LCD_T_1_52MS);
			w_4_1ms: return `LCD_WAIT_W'(`LCD_T_4_1MS);
			w_40ms: return `LCD_WAIT_W'(`LCD_T_40MS);
			w_500ms: return `LCD_WAIT_W'(`LCD_T_500MS);
			default: return `LCD_WAIT_W'(`LCD_T_37US);
		endcase
	endfunction

	assign wbr_cyc = req;
	assign wbr_stb = req;

	always_ff @(posedge clk_270k) begin
		if (rst) begin
			state <= st_req;
			req <= 1'b0;
			cnt <= '0;
			lcd_e <= 1'b0;
			lcd_rs <= 1'b0;
			lcd_data <= 4'h0;
		end else begin
			case (state)
				st_req: begin
					req <= !wbr_ack;
					if (wbr_ack) begin
						if (wbr_dat.kind == kind_pause) begin
							cnt <= wait_count(wbr_dat.wait_cls);
							state <= st_wait;
						end else begin
							lcd_rs <= (wbr_dat.kind == kind_data);
							lcd_data <= wbr_dat.data[7:4];
							state <= st_up_set;
						end
					end
				end
				st_up_set: begin
					lcd_e <= 1'b1;
					state <= st_up_hi;
				end
				st_up_hi: begin
					lcd_e <= 1'b0; // panel latches on this fall
					state <= st_up_lo;
				end
				st_up_lo: begin
					if (item_q.kind == kind_upper) begin
						cnt <= wait_count(item_q.wait_cls);
						state <= st_wait;
					end else begin
						lcd_data <= item_q.data[3:0];
						state <= st_lo_set;
					end
				end
				st_lo_set: begin
					lcd_e <= 1'b1;
					state <= st_lo_hi;
				end
				st_lo_hi: begin
					lcd_e <= 1'b0;
					state <= st_lo_lo;
				end
				st_lo_lo: begin
					cnt <= wait_count(item_q.wait_cls);
					state <= st_wait;
				end
				default: begin
					if (cnt == '0)
						state <= st_req;
					else
						cnt <= cnt - 1'b1;
				end
			endcase
		end
	end

	// kept for the lower nibble and the wait class
	always_ff @(posedge clk_270k) begin
		if (state == st_req && wbr_ack)
			item_q <= wbr_dat;
	end

endmodule

// ==== source/lcd_hex_display.sv ====
module lcd_hex_display (
	input logic clk_270k,
	input logic rst,
	input lcd_pkg::lcd_word_t word_top,
	input lcd_pkg::lcd_word_t word_bottom,
	output logic lcd_e,
	output logic lcd_rs,
	output logic [3:0] lcd_data
);
	import lcd_pkg::*;

	// write link, text source to FIFO
	logic wbw_cyc;
	logic wbw_stb;
	lcd_item_t wbw_dat;
	logic wbw_ack;

	// read link, bus driver from FIFO
	logic wbr_cyc;
	logic wbr_stb;
	logic wbr_ack;
	lcd_item_t wbr_dat;

	lcd_text_source i_lcd_text_source (
		.clk_270k(clk_270k),
		.rst(rst),
		.word_top(word_top),
		.word_bottom(word_bottom),
		.wbw_cyc(wbw_cyc),
		.wbw_stb(wbw_stb),
		.wbw_dat(wbw_dat),
		.wbw_ack(wbw_ack)
	);

	lcd_item_fifo #(
		.item_t(lcd_item_t)
	) i_lcd_item_fifo (
		.clk_270k(clk_270k),
		.rst(rst),
		.wbw_cyc(wbw_cyc),
		.wbw_stb(wbw_stb),
		.wbw_dat(wbw_dat),
		.wbw_ack(wbw_ack),
		.wbr_cyc(wbr_cyc),
		.wbr_stb(wbr_stb),
		.wbr_ack(wbr_ack),
		.wbr_dat(wbr_dat)
	);

	lcd_bus_driver i_lcd_bus_driver (
		.clk_270k(clk_270k),
		.rst(rst),
		.wbr_cyc(wbr_cyc),
		.wbr_stb(wbr_stb),
		.wbr_ack(wbr_ack),
		.wbr_dat(wbr_dat),
		.lcd_e(lcd_e),
		.lcd_rs(lcd_rs),
		.lcd_data(lcd_data)
	);

endmodule

// ==== bench/lcd_hex_display_tb.sv ====
`include "lcd_defines.svh"

module lcd_hex_display_tb;
	import lcd_pkg::*;

	localparam int n_events = 52; // init 8, two frames of 22

	logic clk_270k = 1'b0;
	logic rst;
	lcd_word_t word_top;
	lcd_word_t word_bottom;
	logic lcd_e;
	logic lcd_rs;
	logic [3:0] lcd_data;

	logic [31:0] lfsr_state = 32'hdd3d_5aea;

	// expected bus events
	logic [7:0] exp_byte [64];
	logic exp_rs [64];
	logic exp_upper [64];
	int exp_gap [64];
	int exp_n = 0;
	logic saw_letter = 1'b0;
	logic saw_number = 1'b0;

	// decoder state updated on the falling clock edge
	logic armed = 1'b0;
	logic e_prev = 1'b0;
	logic half = 1'b0;
	logic [3:0] hi_nib;
	int ev_idx = 0;
	int since_rel = 0;
	int gap_cnt = 0;
	logic ev_fire = 1'b0;
	logic [7:0] ev_byte;
	logic [7:0] ev_exp;
	logic nib_fire = 1'b0;
	logic nib_rs;
	logic nib_rs_exp;
	logic gap_fire = 1'b0;
	int gap_seen;
	int gap_min;

	lcd_hex_display i_lcd_hex_display (
		.clk_270k(clk_270k),
		.rst(rst),
		.word_top(word_top),
		.word_bottom(word_bottom),
		.lcd_e(lcd_e),
		.lcd_rs(lcd_rs),
		.lcd_data(lcd_data)
	);

	always #20 clk_270k = ~clk_270k;

	task automatic stop_run(string why);
		$display("** FAIL **");
		$fatal(1, "%s", why);
	endtask

	task automatic value_error(string sig, logic [31:0] exp_v, logic [31:0] act_v);
		$display("ERR time=%0t signal=%s expected=0x%0h actual=0x%0h",
			$time, sig, exp_v, act_v);
		stop_run("value mismatch on the LCD bus");
	endtask

	function automatic logic [31:0] lfsr_step(logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		else
			return s >> 1;
	endfunction

	task automatic draw_word(output lcd_word_t w);
		for (int i = 31; i >= 0; i--) begin
			lfsr_state = lfsr_step(lfsr_state);
			w[i] = lfsr_state[0];
		end
	endtask

	// ascii upper-case hex digit
	function automatic logic [7:0] ascii_hex(logic [3:0] n);
		if (n <= 4'd9)
			return 8'h30 + {4'h0, n};
		return 8'h41 + {4'h0, n} - 8'd10;
	endfunction

	task automatic add_event(logic [7:0] b, logic rs_v, logic upper, int gap);
		exp_byte[exp_n] = b;
		exp_rs[exp_n] = rs_v;
		exp_upper[exp_n] = upper;
		exp_gap[exp_n] = gap;
		exp_n++;
	endtask

	task automatic add_line(lcd_word_t w);
		logic [3:0] n;
		add_event(8'h30, 1'b1, 1'b0, `LCD_T_37US);
		add_event(8'h78, 1'b1, 1'b0, `LCD_T_37US);
		for (int i = 7; i >= 0; i--) begin
			n = w[i*4 +: 4];
			if (n > 4'd9)
				saw_letter = 1'b1;
			else
				saw_number = 1'b1;
			add_event(ascii_hex(n), 1'b1, 1'b0, `LCD_T_37US);
		end
	endtask

	task automatic add_frame(lcd_word_t top, lcd_word_t bottom);
		add_line(top);
		add_event(8'hC0, 1'b0, 1'b0, `LCD_T_37US);
		add_line(bottom);
		add_event(8'h02, 1'b0, 1'b0, `LCD_T_1_52MS + `LCD_T_500MS); // home, then refresh pause
	endtask

	task automatic add_init();
		add_event(8'h30, 1'b0, 1'b1, `LCD_T_4_1MS);
		add_event(8'h30, 1'b0, 1'b1, `LCD_T_100US);
		add_event(8'h30, 1'b0, 1'b1, `LCD_T_37US);
		add_event(8'h20, 1'b0, 1'b1, `LCD_T_37US);
		add_event(8'h28, 1'b0, 1'b0, `LCD_T_37US);
		add_event(8'h0F, 1'b0, 1'b0, `LCD_T_37US);
		add_event(8'h01, 1'b0, 1'b0, `LCD_T_1_52MS);
		add_event(8'h06, 1'b0, 1'b0, `LCD_T_37US);
	endtask

	task automatic wait_events(int target, int limit, string what);
		int cycles;
		cycles = 0;
		while (ev_idx < target && cycles < limit) begin
			@(negedge clk_270k);
			cycles++;
		end
		if (ev_idx < target)
			stop_run(what);
	endtask

	always @(negedge clk_270k) begin
		armed <= 1'b1;
		e_prev <= lcd_e;
		ev_fire <= 1'b0;
		nib_fire <= 1'b0;
		gap_fire <= 1'b0;
		if (rst)
			since_rel <= 0;
		else if (since_rel < 32'h4000_0000)
			since_rel <= since_rel + 1;
		if (gap_cnt < 32'h4000_0000)
			gap_cnt <= gap_cnt + 1;
		// first rise of an item
		if (!e_prev && lcd_e && !half && ev_idx > 0) begin
			gap_fire <= 1'b1;
			gap_seen <= gap_cnt + 1;
			gap_min <= exp_gap[ev_idx - 1];
		end
		if (e_prev && !lcd_e) begin
			nib_fire <= 1'b1;
			nib_rs <= lcd_rs;
			nib_rs_exp <= exp_rs[ev_idx];
			if (ev_idx < 4 || half) begin
				ev_fire <= 1'b1;
				ev_byte <= (ev_idx < 4) ? {lcd_data, 4'h0} : {hi_nib, lcd_data};
				ev_exp <= exp_upper[ev_idx] ? {exp_byte[ev_idx][7:4], 4'h0} : exp_byte[ev_idx];
				ev_idx <= ev_idx + 1;
				half <= 1'b0;
				gap_cnt <= 0;
			end else begin
				hi_nib <= lcd_data;
				half <= 1'b1;
			end
		end
	end

	a_e_quiet: assert property (@(posedge clk_270k)
		armed && (rst || since_rel < `LCD_T_40MS) |-> !lcd_e)
		else value_error("lcd_e", 32'd0, 32'($sampled(lcd_e)));

	a_rs_quiet: assert property (@(posedge clk_270k)
		armed && (rst || since_rel < `LCD_T_40MS) |-> !lcd_rs)
		else value_error("lcd_rs", 32'd0, 32'($sampled(lcd_rs)));

	a_data_reset: assert property (@(posedge clk_270k) armed && rst |-> lcd_data == 4'h0)
		else value_error("lcd_data", 32'd0, 32'($sampled(lcd_data)));

	a_byte: assert property (@(posedge clk_270k) ev_fire |-> ev_byte == ev_exp)
		else value_error("lcd_data", 32'(ev_exp), 32'(ev_byte));

	a_rs: assert property (@(posedge clk_270k) nib_fire |-> nib_rs == nib_rs_exp)
		else value_error("lcd_rs", 32'(nib_rs_exp), 32'(nib_rs));

	a_gap: assert property (@(posedge clk_270k) gap_fire |-> gap_seen >= gap_min)
		else value_error("lcd_e gap", 32'(gap_min), 32'(gap_seen));

	initial begin
		lcd_word_t w_top;
		lcd_word_t w_bottom;
		rst = 1'b1;
		draw_word(w_top);
		draw_word(w_bottom);
		word_top = w_top;
		word_bottom = w_bottom;
		add_init();
		add_frame(w_top, w_bottom);
		repeat (4) @(negedge clk_270k);
		rst <= 1'b0;

		// the source reads its words a few items ahead of the bus,
		// so the next pair goes in once line 2 starts
		wait_events(19, `LCD_T_40MS * 3, "no line change seen in the first frame");
		draw_word(w_top);
		draw_word(w_bottom);
		word_top <= w_top;
		word_bottom <= w_bottom;
		add_frame(w_top, w_bottom);

		wait_events(n_events, `LCD_T_500MS * 2, "second frame did not complete");
		if (saw_letter && saw_number) begin
			$display("** PASS **");
			$finish;
		end else begin
			stop_run("random words missed letter or number digits");
		end
	end

endmodule

// ==== vlog.f ====
+incdir+source
source/lcd_pkg.sv
source/lcd_text_source.sv
source/lcd_item_fifo.sv
source/lcd_bus_driver.sv
source/lcd_hex_display.sv
bench/lcd_hex_display_tb.sv

// ==== Makefile ====
# Verilator build for the HD44780 hex display testbench

VERILATOR ?= verilator
TOP ?= lcd_hex_display_tb
FILELIST ?= vlog.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
SIM ?= $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard source/*.sv source/*.svh bench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# a $$fatal in the testbench gives a nonzero exit status
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
